// File: filtered_ram_top.f
hw/nabp_types_pkg.sv
hw/swap_ctrl_pkg.sv
hw/filtered_ram_if.sv
hw/ramp_fir.sv
hw/filtered_ram_swappable.sv
hw/filtered_ram_swap_control.sv
hw/filtered_ram_top.sv
sim/tb_filtered_ram_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the filtered RAM testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f filtered_ram_top.f \
    --top-module tb_filtered_ram_top \
    --Mdir obj_dir -o tb_filtered_ram_top

./obj_dir/tb_filtered_ram_top 2>&1 | tee sim.log

if grep -q "Regression failed" sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi

echo "simulation finished, log in sim.log"

// File: sim/tb_filtered_ram_top.sv
module tb_filtered_ram_top
    import nabp_types_pkg::*;
;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // run length
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int NUM_ANGLES = 6;
    // host read latency plus FIR stages
    localparam int FILL_DELAY = HOST_LATENCY + FIR_LATENCY;
    // room for eight lines, each fill plus hand-off slack
    localparam int TIMEOUT_CYCLES = 8 * (S_LEN + FILL_DELAY + 40);

    logic clk;
    logic reset_n;
    // host side
    angle_t hs_angle;
    logic hs_has_next_angle;
    logic hs_next_angle_ack;
    raw_t hs_raw_val;
    s_t hs_s_val;
    logic hs_next_angle;
    // processing side
    angle_t pr_angle;
    logic pr_has_next_angle;
    logic pr_next_angle;
    logic pr_prev_angle_release;
    logic pr_next_angle_ack;
    logic pr_prev_angle_release_ack;
    s_t pr0_s_val;
    s_t pr1_s_val;
    filt_t pr0_val;
    filt_t pr1_val;

    // host RAM contents, one raw line per angle
    raw_t lines [NUM_ANGLES][S_LEN];
    angle_t angle_of [NUM_ANGLES];
    integer seed;

    // host model state
    int host_idx;
    logic next_seen;
    s_t addr_q;
    int line_q;
    // fill addresses still expected after the last ack
    int fill_left;
    s_t fill_exp;

    // read requests from the processing model, one per cycle
    logic rd_req;
    int rd_s;
    int rd_a0;
    int rd_a1;
    // same request one cycle later, lined up with read data
    logic cmp_v;
    int cmp_s;
    int cmp_a0;
    int cmp_a1;

    int mismatch_count;
    int fail_count;
    int cycle_count;

    filtered_ram_top u_dut (
        .clk (clk),
        .reset_n (reset_n),
        .hs_angle (hs_angle),
        .hs_has_next_angle (hs_has_next_angle),
        .hs_next_angle_ack (hs_next_angle_ack),
        .hs_raw_val (hs_raw_val),
        .hs_s_val (hs_s_val),
        .hs_next_angle (hs_next_angle),
        .pr_angle (pr_angle),
        .pr_has_next_angle (pr_has_next_angle),
        .pr_next_angle (pr_next_angle),
        .pr_prev_angle_release (pr_prev_angle_release),
        .pr_next_angle_ack (pr_next_angle_ack),
        .pr_prev_angle_release_ack (pr_prev_angle_release_ack),
        .pr0_s_val (pr0_s_val),
        .pr1_s_val (pr1_s_val),
        .pr0_val (pr0_val),
        .pr1_val (pr1_val)
    );

    always #5 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference and compare helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ramp taps -1 2 -1, samples before the line start count as zero
    function automatic filt_t ref_filtered(int idx, int s);
        int x0;
        int x1;
        int x2;
        x0 = lines[idx][s];
        x1 = (s >= 1) ? int'(lines[idx][s-1]) : 0;
        x2 = (s >= 2) ? int'(lines[idx][s-2]) : 0;
        ref_filtered = filt_t'(2 * x1 - x0 - x2);
    endfunction

    task automatic check_filt(filt_t got, filt_t exp, string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_angle(angle_t got, angle_t exp, string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_addr(s_t got, s_t exp, string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic print_summary();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host RAM model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sample request and fill address mid cycle
    always @(negedge clk)
    begin
        next_seen = reset_n && (hs_next_angle === 1'b1);
        addr_q = hs_s_val;
        line_q = (host_idx > 0) ? host_idx - 1 : 0;
        // addresses 0 .. S_LEN-1 in the cycles right after the ack
        if (fill_left > 0)
        begin
            check_addr(hs_s_val, fill_exp, "hs_s_val during fill");
            fill_exp = fill_exp + 1'b1;
            fill_left--;
        end
    end

    // ack pulse is one cycle, angle index moves on after it
    always @(posedge clk)
    begin
        #1;
        if (hs_next_angle_ack)
        begin
            hs_next_angle_ack = 1'b0;
            host_idx = host_idx + 1;
            fill_left = S_LEN;
            fill_exp = '0;
        end
        else if (next_seen && host_idx < NUM_ANGLES)
            hs_next_angle_ack = 1'b1;
        // angle of the line most recently handed out
        hs_angle = (host_idx > 0) ? angle_of[host_idx-1] : '0;
        hs_has_next_angle = (host_idx < NUM_ANGLES);
        // one cycle read latency
        hs_raw_val = lines[line_q][addr_q];
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read data compare
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk)
    begin
        if (cmp_v)
        begin
            check_filt(pr0_val, ref_filtered(cmp_a0, cmp_s),
                       $sformatf("pr0_val angle %0d addr %0d", cmp_a0, cmp_s));
            check_filt(pr1_val, ref_filtered(cmp_a1, cmp_s),
                       $sformatf("pr1_val angle %0d addr %0d", cmp_a1, cmp_s));
        end
        cmp_v = rd_req;
        cmp_s = rd_s;
        cmp_a0 = rd_a0;
        cmp_a1 = rd_a1;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // processing model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sweep every address on both ports, one per cycle
    task automatic read_lines(int a0, int a1);
        for (int i = 0; i < S_LEN; i++)
        begin
            @(posedge clk);
            #1;
            pr0_s_val = s_t'(i);
            pr1_s_val = s_t'(i);
            rd_req = 1'b1;
            rd_s = i;
            rd_a0 = a0;
            rd_a1 = a1;
        end
        @(posedge clk);
        #1;
        rd_req = 1'b0;
    endtask

    // hold the request until its ack shows up
    task automatic request_next();
        @(posedge clk);
        #1;
        pr_next_angle = 1'b1;
        @(negedge clk);
        while (pr_next_angle_ack !== 1'b1)
            @(negedge clk);
        @(posedge clk);
        #1;
        pr_next_angle = 1'b0;
    endtask

    task automatic request_release();
        @(posedge clk);
        #1;
        pr_prev_angle_release = 1'b1;
        @(negedge clk);
        while (pr_prev_angle_release_ack !== 1'b1)
            @(negedge clk);
        @(posedge clk);
        #1;
        pr_prev_angle_release = 1'b0;
    endtask

    // hang guard
    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        fail_count++;
        print_summary();
        $finish;
    end

    initial
    begin
        clk = 1'b0;
        reset_n = 1'b0;
        hs_angle = '0;
        hs_has_next_angle = 1'b1;
        hs_next_angle_ack = 1'b0;
        hs_raw_val = '0;
        pr_next_angle = 1'b0;
        pr_prev_angle_release = 1'b0;
        pr0_s_val = '0;
        pr1_s_val = '0;
        host_idx = 0;
        next_seen = 1'b0;
        addr_q = '0;
        line_q = 0;
        fill_left = 0;
        fill_exp = '0;
        rd_req = 1'b0;
        rd_s = 0;
        rd_a0 = 0;
        rd_a1 = 0;
        cmp_v = 1'b0;
        mismatch_count = 0;
        fail_count = 0;

        // random lines and angle labels
        seed = 32'h3de6fb38;
        for (int a = 0; a < NUM_ANGLES; a++)
        begin
            angle_of[a] = angle_t'($random(seed));
            for (int s = 0; s < S_LEN; s++)
                lines[a][s] = raw_t'($random(seed));
        end

        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;

        // idle state right out of reset
        @(negedge clk);
        check_bit(hs_next_angle, 1'b1, "hs_next_angle after reset");
        check_bit(pr_has_next_angle, 1'b1, "pr_has_next_angle after reset");
        check_bit(pr_next_angle_ack, 1'b0, "pr_next_angle_ack after reset");
        check_bit(pr_prev_angle_release_ack, 1'b0, "pr_prev_angle_release_ack after reset");

        // first line becomes the working buffer
        request_release();
        @(negedge clk);
        check_angle(pr_angle, angle_of[0], "pr_angle after first release");
        check_bit(pr_has_next_angle, 1'b1, "pr_has_next_angle after first release");
        read_lines(0, 0);

        for (int k = 1; k < NUM_ANGLES; k++)
        begin
            // diverged, pr1 on the new line and pr0 still on the old one
            request_next();
            @(negedge clk);
            check_angle(pr_angle, angle_of[k], "pr_angle after next angle ack");
            check_bit(pr_has_next_angle, logic'(k < NUM_ANGLES - 1),
                      "pr_has_next_angle after next angle ack");
            read_lines(k - 1, k);
            // old line released, both ports on the new one
            request_release();
            @(negedge clk);
            check_angle(pr_angle, angle_of[k], "pr_angle after release");
            check_bit(pr_has_next_angle, logic'(k < NUM_ANGLES - 1),
                      "pr_has_next_angle after release");
            read_lines(k, k);
        end

        // control back in ready_s asking for more
        @(negedge clk);
        check_bit(hs_next_angle, 1'b1, "hs_next_angle after last line");
        check_bit(pr_has_next_angle, 1'b0, "pr_has_next_angle after last line");
        if (host_idx != NUM_ANGLES)
        begin
            $display("Host handed out %0d of %0d angles", host_idx, NUM_ANGLES);
            fail_count++;
        end

        print_summary();
        $finish;
    end

endmodule

// File: hw/filtered_ram_top.sv
module filtered_ram_top
    import nabp_types_pkg::*;
#(
    // address to write distance inside the line buffers
    parameter int FILL_DELAY = HOST_LATENCY + FIR_LATENCY
)
(
    input logic clk,
    input logic reset_n,
    // host
    input angle_t hs_angle,
    input logic hs_has_next_angle,
    input logic hs_next_angle_ack,
    input raw_t hs_raw_val,
    output s_t hs_s_val,
    output logic hs_next_angle,
    // processing
    output angle_t pr_angle,
    output logic pr_has_next_angle,
    input logic pr_next_angle,
    input logic pr_prev_angle_release,
    output logic pr_next_angle_ack,
    output logic pr_prev_angle_release_ack,
    input s_t pr0_s_val,
    input s_t pr1_s_val,
    output filt_t pr0_val,
    output filt_t pr1_val
);

    logic fir_clear;
    filt_t filt_val;

    filtered_ram_if sw0_bus ();
    filtered_ram_if sw1_bus ();

    // host sample -> filtered sample
    ramp_fir u_fir (
        .clk (clk),
        .reset_n (reset_n),
        .clear (fir_clear),
        .in_val (hs_raw_val),
        .out_val (filt_val)
    );

    filtered_ram_swap_control u_ctrl (
        .clk (clk),
        .reset_n (reset_n),
        .hs_angle (hs_angle),
        .hs_has_next_angle (hs_has_next_angle),
        .hs_next_angle_ack (hs_next_angle_ack),
        .hs_val (filt_val),
        .hs_s_val (hs_s_val),
        .hs_next_angle (hs_next_angle),
        .fir_clear (fir_clear),
        .pr_angle (pr_angle),
        .pr_has_next_angle (pr_has_next_angle),
        .pr_next_angle (pr_next_angle),
        .pr_prev_angle_release (pr_prev_angle_release),
        .pr_next_angle_ack (pr_next_angle_ack),
        .pr_prev_angle_release_ack (pr_prev_angle_release_ack),
        .pr0_s_val (pr0_s_val),
        .pr1_s_val (pr1_s_val),
        .pr0_val (pr0_val),
        .pr1_val (pr1_val),
        .sw0 (sw0_bus),
        .sw1 (sw1_bus)
    );

    // double buffer
    filtered_ram_swappable #(.FILL_DELAY(FILL_DELAY)) u_sw0 (
        .clk (clk),
        .reset_n (reset_n),
        .bus (sw0_bus)
    );

    filtered_ram_swappable #(.FILL_DELAY(FILL_DELAY)) u_sw1 (
        .clk (clk),
        .reset_n (reset_n),
        .bus (sw1_bus)
    );

endmodule

// File: hw/filtered_ram_swap_control.sv
module filtered_ram_swap_control
    import nabp_types_pkg::*;
    import swap_ctrl_pkg::*;
(
    input logic clk,
    input logic reset_n,
    // host
    input angle_t hs_angle,
    input logic hs_has_next_angle,
    input logic hs_next_angle_ack,
    input filt_t hs_val,
    output s_t hs_s_val,
    output logic hs_next_angle,
    output logic fir_clear,
    // processing
    output angle_t pr_angle,
    output logic pr_has_next_angle,
    input logic pr_next_angle,
    input logic pr_prev_angle_release,
    output logic pr_next_angle_ack,
    output logic pr_prev_angle_release_ack,
    input s_t pr0_s_val,
    input s_t pr1_s_val,
    output filt_t pr0_val,
    output filt_t pr1_val,
    // the two line buffers
    filtered_ram_if.ctrl sw0,
    filtered_ram_if.ctrl sw1
);

    swap_state_t state;
    swap_state_t next_state;

    // sw_sel | sw0     | sw1
    //      0 | working | filling
    //      1 | filling | working
    logic sw_sel;
    sw_role_t sw0_role;
    sw_role_t sw1_role;

    logic fill_done;
    logic fill_kick;
    logic swap;
    logic swap_curr;
    logic swap_prev;
    logic diverged;
    logic prev_angle_release;

    assign sw0_role = sw_sel ? filling : working;
    assign sw1_role = sw_sel ? working : filling;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // mux and demux to the line buffers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // status and fill address come from the filling buffer
    assign fill_done = (sw0_role == filling) ? sw0.fill_done : sw1.fill_done;
    assign hs_s_val = (sw0_role == filling) ? sw0.hs_s_val : sw1.hs_s_val;
    // kick goes to the working buffer, it turns filling on the same edge
    assign sw0.fill_kick = (sw0_role == working) && fill_kick;
    assign sw1.fill_kick = (sw1_role == working) && fill_kick;
    // only the sequenced buffer writes, data can go to both
    assign sw0.hs_val = hs_val;
    assign sw1.hs_val = hs_val;
    assign sw0.pr0_s_val = pr0_s_val;
    assign sw1.pr0_s_val = pr0_s_val;
    assign sw0.pr1_s_val = pr1_s_val;
    assign sw1.pr1_s_val = pr1_s_val;

    // sw_sel diverged | pr0 pr1
    //      0        0 | sw0 sw0
    //      0        1 | sw0 sw1
    //      1        0 | sw1 sw1
    //      1        1 | sw1 sw0
    assign diverged = (state == diverged_work_s);
    assign pr0_val = (sw0_role == working) ? sw0.pr0_val : sw1.pr0_val;
    assign pr1_val = (sw_sel ^ diverged) ? sw1.pr1_val : sw0.pr1_val;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // swap detection and hand-off strobes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // release the oldest angle once the filling buffer is done,
    // only when advancing, never while entering the diverged mode
    assign prev_angle_release = pr_prev_angle_release && fill_done &&
                                ((state == fill_s) || (state == diverged_work_s));

    // host ack when there is another angle, else the release itself
    assign swap_curr = hs_has_next_angle ? hs_next_angle_ack : prev_angle_release;
    assign swap = swap_curr && !swap_prev;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            swap_prev <= 1'b0;
        else
            swap_prev <= swap_curr;
    end

    assign fill_kick = swap && hs_has_next_angle;
    // FIR history restarts with every line
    assign fir_clear = fill_kick;

    assign hs_next_angle = (state == ready_s) || prev_angle_release;
    assign pr_prev_angle_release_ack = (state != ready_s) && pr_prev_angle_release && swap;
    // next buffer done, so pr1 can start on it
    assign pr_next_angle_ack = pr_next_angle && fill_done && (state == fill_and_work_s);

    // angle seen by processing
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            pr_angle <= '0;
            // processing starts out expecting an angle
            pr_has_next_angle <= 1'b1;
        end
        else if (pr_next_angle_ack || pr_prev_angle_release_ack)
        begin
            pr_angle <= hs_angle;
            pr_has_next_angle <= hs_has_next_angle;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // mealy FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= ready_s;
            sw_sel <= 1'b0;
        end
        else
        begin
            state <= next_state;
            if (swap)
                sw_sel <= !sw_sel;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            ready_s:
                if (hs_next_angle_ack)
                    next_state = fill_s;
            fill_s:
                if (swap)
                    next_state = hs_has_next_angle ? fill_and_work_s : work_s;
            fill_and_work_s:
                if (pr_next_angle_ack)
                    next_state = diverged_work_s;
            diverged_work_s:
                if (pr_prev_angle_release_ack)
                    next_state = hs_has_next_angle ? fill_and_work_s : work_s;
            work_s:
                // last line settled, go ask again
                if (fill_done)
                    next_state = ready_s;
            default:
                next_state = ready_s;
        endcase
    end

    // processing may hold both requests, only one is answered per cycle
    a_one_ack: assert property (
        @(posedge clk) disable iff (!reset_n)
        !(pr_next_angle_ack && pr_prev_angle_release_ack)
    ) else $error("next angle and release acked together");

    // pr1 reads the next line, so it stays complete while diverged
    a_diverge_done: assert property (
        @(posedge clk) disable iff (!reset_n)
        (state == diverged_work_s) |-> fill_done
    ) else $error("diverged while the filling buffer is incomplete, sw0 %s",
                  sw0_role.name());

    // in ready_s the only swap is the host answering our request
    a_ready_swap: assert property (
        @(posedge clk) disable iff (!reset_n)
        (state == ready_s && swap) |-> $past(hs_next_angle)
    ) else $error("stray swap in ready_s, sw0 %s", sw0_role.name());

endmodule

// File: hw/filtered_ram_swappable.sv
module filtered_ram_swappable
    import nabp_types_pkg::*;
#(
    parameter int FILL_DELAY = 3
)
(
    input logic clk,
    input logic reset_n,
    filtered_ram_if.ram bus
);

    // one filtered projection line
    filt_t mem [S_LEN];

    // fill sequencer
    logic filling;
    s_t fill_addr;

    // address delay pipe, meets the filtered sample FILL_DELAY later
    logic [FILL_DELAY-1:0] wr_v;
    s_t wr_s [FILL_DELAY];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fill address generation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // kick in cycle k, addresses 0 .. S_LEN-1 in k+1 .. k+S_LEN
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            filling <= 1'b0;
            fill_addr <= '0;
        end
        else if (bus.fill_kick)
        begin
            filling <= 1'b1;
            fill_addr <= '0;
        end
        else if (filling)
        begin
            fill_addr <= fill_addr + 1'b1;
            // last address of the line
            if (fill_addr == s_t'(S_LEN - 1))
                filling <= 1'b0;
        end
    end

    assign bus.hs_s_val = fill_addr;

    // valid bits of the pipe
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            wr_v <= '0;
        else
            wr_v <= (wr_v << 1) | FILL_DELAY'(filling);
    end

    // addresses ride along
    always_ff @(posedge clk)
    begin
        wr_s[0] <= fill_addr;
        for (int i = 1; i < FILL_DELAY; i++)
            wr_s[i] <= wr_s[i-1];
    end

    // write lands FILL_DELAY cycles after its address
    always_ff @(posedge clk)
    begin
        if (wr_v[FILL_DELAY-1])
            mem[wr_s[FILL_DELAY-1]] <= bus.hs_val;
    end

    // low from the cycle after the kick until the last write is done
    assign bus.fill_done = !filling && !(|wr_v);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read ports
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data one cycle after address
    always_ff @(posedge clk)
    begin
        bus.pr0_val <= mem[bus.pr0_s_val];
        bus.pr1_val <= mem[bus.pr1_s_val];
    end

    // the control must not restart a line that is still filling
    a_kick_when_done: assert property (
        @(posedge clk) disable iff (!reset_n)
        bus.fill_kick |-> bus.fill_done
    ) else $error("fill kick while line buffer still filling");

endmodule

// File: hw/ramp_fir.sv
module ramp_fir
    import nabp_types_pkg::*;
(
    input logic clk,
    input logic reset_n,
    input logic clear,
    input raw_t in_val,
    output filt_t out_val
);

    // x[n-1] and x[n-2]
    raw_t x0;
    raw_t x1;
    // clear history, one bit per host latency cycle
    logic [HOST_LATENCY-1:0] clr_sr;
    logic hold;
    // stage 1 tap products
    filt_t prod0;
    filt_t prod1;
    filt_t prod2;

    // zero extend raw sample into the signed domain
    function automatic filt_t widen(raw_t v);
        widen = filt_t'(v);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // delay line
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // clear comes with the fill kick, the first sample of the line
    // shows up HOST_LATENCY cycles later, so keep history at zero
    // until then
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            clr_sr <= '0;
        else
            clr_sr <= (clr_sr << 1) | HOST_LATENCY'(clear);
    end

    assign hold = clear || (|clr_sr);

    always_ff @(posedge clk)
    begin
        if (hold)
        begin
            x0 <= '0;
            x1 <= '0;
        end
        else
        begin
            x0 <= in_val;
            x1 <= x0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // products, then sum
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        prod0 <= FIR_TAP0 * widen(in_val);
        prod1 <= FIR_TAP1 * widen(x0);
        prod2 <= FIR_TAP2 * widen(x1);
    end

    // worst case magnitude 4 * (2^RAW_W - 1) fits FILT_W
    always_ff @(posedge clk)
    begin
        out_val <= prod0 + prod1 + prod2;
    end

endmodule

// File: hw/filtered_ram_if.sv
interface filtered_ram_if
    import nabp_types_pkg::*;
();

    // fill handshake
    logic fill_kick;
    logic fill_done;
    // host side fill address and filtered write data
    s_t hs_s_val;
    filt_t hs_val;
    // processing side read ports
    s_t pr0_s_val;
    s_t pr1_s_val;
    filt_t pr0_val;
    filt_t pr1_val;

    // swap control end
    modport ctrl (
        output fill_kick, hs_val, pr0_s_val, pr1_s_val,
        input fill_done, hs_s_val, pr0_val, pr1_val
    );

    // line buffer end
    modport ram (
        input fill_kick, hs_val, pr0_s_val, pr1_s_val,
        output fill_done, hs_s_val, pr0_val, pr1_val
    );

endinterface

// File: hw/swap_ctrl_pkg.sv
package swap_ctrl_pkg;

    // swap FSM states
    // ready_s          idle, asks the host for the first angle
    // fill_s           first buffer filling, nothing to work on yet
    // fill_and_work_s  one buffer filling, the other being worked
    // diverged_work_s  pr0 on current angle, pr1 on next angle
    // work_s           last angle, no more fills
    typedef enum logic [2:0] {
        ready_s,
        fill_s,
        fill_and_work_s,
        diverged_work_s,
        work_s
    } swap_state_t;

    // role of a swappable for a given select bit
    typedef enum logic {
        working,
        filling
    } sw_role_t;

endpackage

// File: hw/nabp_types_pkg.sv
package nabp_types_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sample and index widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // raw host sample, unsigned
    parameter int RAW_W = 12;
    // filtered sample, two's complement
    parameter int FILT_W = 16;
    // samples per projection line
    parameter int S_LEN = 32;
    parameter int S_W = $clog2(S_LEN);
    parameter int ANGLE_W = 8;

    typedef logic [RAW_W-1:0] raw_t;
    typedef logic signed [FILT_W-1:0] filt_t;
    typedef logic [S_W-1:0] s_t;
    typedef logic [ANGLE_W-1:0] angle_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ramp filter and latencies
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // y[n] = -x[n] + 2 x[n-1] - x[n-2]
    parameter filt_t FIR_TAP0 = -1;
    parameter filt_t FIR_TAP1 = 2;
    parameter filt_t FIR_TAP2 = -1;
    // product stage plus sum stage
    parameter int FIR_LATENCY = 2;
    // host RAM answers an address one cycle later
    parameter int HOST_LATENCY = 1;

endpackage
